//--- include/lsu_macros.svh
/*
 * vector LSU widths
 * fixed register and memory port sizes shared by the package and the RTL
 */
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// vector register width in bits
`define LSU_VREG_W 128

// memory port data width in bits
`define LSU_VMEM_W 32

// memory beats needed to move one register
`define LSU_BEATS_PER_VREG 4

// byte enables per memory beat
`define LSU_BE_W 4

// default number of load beats in flight
`define LSU_QUEUE_DEPTH 4

`endif

//--- hdl/lsu_pkg.sv
/*
 * vector LSU types
 * data, address, mask and counter types plus the encodings used by the LSU
 */
`include "lsu_macros.svh"

package lsu_pkg;

    //////////////////////////////
    // data and address types
    typedef logic [`LSU_VREG_W-1:0]   vreg_t;
    typedef logic [`LSU_VREG_W/8-1:0] vmask_t;
    // one bit per element index of the whole group
    typedef logic [`LSU_VREG_W-1:0]   elem_mask_t;
    typedef logic [31:0]              addr_t;
    typedef logic [`LSU_VMEM_W-1:0]   word_t;
    typedef logic [`LSU_BE_W-1:0]     be_t;

    //////////////////////////////
    // counters and indices
    // vl reaches 128 for 8-bit elements in a group of 8
    typedef logic [7:0] vl_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [4:0] beat_cnt_t;

    //////////////////////////////
    // encodings
    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    // encoded as log2 of the register count
    typedef enum logic [1:0] {
        LMUL_1 = 2'd0,
        LMUL_2 = 2'd1,
        LMUL_4 = 2'd2,
        LMUL_8 = 2'd3
    } lmul_e;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        FETCH = 2'd1,
        ISSUE = 2'd2
    } req_state_e;

endpackage

//--- hdl/lsu_load_queue.sv
/*
 * vector LSU load queue
 * circular FIFO with target register and byte enables of granted load beats
 */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_load_queue #(
    parameter int unsigned DEPTH = `LSU_QUEUE_DEPTH
) (
    input  logic               clk_i,
    input  logic               async_rst_ni,
    input  logic               push_i,
    input  lsu_pkg::reg_idx_t  push_reg_i,
    input  lsu_pkg::be_t       push_be_i,
    input  logic               pop_i,
    output logic               full_o,
    output logic               empty_o,
    output lsu_pkg::reg_idx_t  head_reg_o,
    output lsu_pkg::be_t       head_be_o
);
    import lsu_pkg::*;

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    reg_idx_t         reg_mem [DEPTH];
    be_t              be_mem  [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // occupancy holds when both happen in one cycle
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            reg_mem[wr_ptr_q] <= push_reg_i;
            be_mem[wr_ptr_q]  <= push_be_i;
        end
    end

    assign head_reg_o = reg_mem[rd_ptr_q];
    assign head_be_o  = be_mem[rd_ptr_q];

endmodule

//--- hdl/lsu_load_wb.sv
/*
 * vector LSU load write-back
 * collects returned load words into a register and writes it with its byte mask
 */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_load_wb (
    input  logic               clk_i,
    input  logic               async_rst_ni,
    input  logic               rvalid_i,
    input  lsu_pkg::word_t     rdata_i,
    input  lsu_pkg::reg_idx_t  beat_reg_i,
    input  lsu_pkg::be_t       beat_be_i,
    output logic               idle_o,
    output logic               vreg_wr_en_o,
    output lsu_pkg::reg_idx_t  vreg_wr_addr_o,
    output lsu_pkg::vreg_t     vreg_wr_data_o,
    output lsu_pkg::vmask_t    vreg_wr_mask_o
);
    import lsu_pkg::*;

    localparam int unsigned CNT_W = $clog2(`LSU_BEATS_PER_VREG);

    logic [CNT_W-1:0] cnt_q;
    logic             wr_en_q;
    vmask_t           mask_q;
    vmask_t           mask_base;
    vreg_t            data_q;
    reg_idx_t         reg_q;

    // a finished register leaves this cycle, so the next one starts from zero
    assign mask_base = wr_en_q ? '0 : mask_q;

    //////////////////////////////
    // beat count and byte mask
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            cnt_q   <= '0;
            wr_en_q <= 1'b0;
            mask_q  <= '0;
        end else begin
            // write goes out the cycle after the last beat of a register
            wr_en_q <= rvalid_i & (&cnt_q);
            if (rvalid_i) begin
                cnt_q  <= cnt_q + 1'b1;
                mask_q <= {beat_be_i, mask_base[`LSU_VREG_W/8-1:`LSU_BE_W]};
            end else if (wr_en_q) begin
                mask_q <= '0;
            end
        end
    end

    //////////////////////////////
    // data assembly
    // first beat ends up in the low word
    always_ff @(posedge clk_i) begin
        if (rvalid_i) begin
            data_q <= {rdata_i, data_q[`LSU_VREG_W-1:`LSU_VMEM_W]};
            reg_q  <= beat_reg_i;
        end
    end

    assign idle_o         = (cnt_q == '0);
    assign vreg_wr_en_o   = wr_en_q;
    assign vreg_wr_addr_o = reg_q;
    assign vreg_wr_data_o = data_q;
    assign vreg_wr_mask_o = mask_q;

endmodule

//--- hdl/lsu_req_gen.sv
/*
 * vector LSU request generator
 * takes one instruction, fetches store data and issues one memory request per beat
 */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_req_gen (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,
    input  logic                 op_valid_i,
    input  logic                 op_store_i,
    input  logic                 op_masked_i,
    input  lsu_pkg::eew_e        op_eew_i,
    input  lsu_pkg::lmul_e       op_lmul_i,
    input  lsu_pkg::vl_t         op_vl_i,
    input  lsu_pkg::addr_t       op_addr_i,
    input  lsu_pkg::reg_idx_t    op_vd_i,
    input  lsu_pkg::elem_mask_t  v0_mask_i,
    input  lsu_pkg::vreg_t       vreg_rd_i,
    input  logic                 data_gnt_i,
    input  logic                 full_i,
    input  logic                 empty_i,
    input  logic                 wb_idle_i,
    output logic                 op_ready_o,
    output logic                 misaligned_o,
    output lsu_pkg::reg_idx_t    vreg_rd_addr_o,
    output logic                 data_req_o,
    output lsu_pkg::addr_t       data_addr_o,
    output logic                 data_we_o,
    output lsu_pkg::be_t         data_be_o,
    output lsu_pkg::word_t       data_wdata_o,
    output logic                 push_o,
    output lsu_pkg::reg_idx_t    push_reg_o,
    output lsu_pkg::be_t         push_be_o
);
    import lsu_pkg::*;

    localparam int unsigned BEAT_LSB = $clog2(`LSU_BEATS_PER_VREG);

    req_state_e state_q;
    beat_cnt_t  beat_q;
    logic       fresh_q;

    // latched instruction
    logic       store_q;
    logic       masked_q;
    eew_e       eew_q;
    lmul_e      lmul_q;
    vl_t        vl_q;
    reg_idx_t   vd_q;
    addr_t      addr_q;
    vreg_t      shift_q;

    logic       accept;
    logic       granted;
    logic       last_beat;
    logic       reg_end;
    beat_cnt_t  beat_max;
    reg_idx_t   cur_vd;
    vreg_t      cur_data;
    be_t        be;

    assign op_ready_o   = (state_q == IDLE) & empty_i & wb_idle_i;
    assign accept       = op_valid_i & op_ready_o;
    assign misaligned_o = accept & (op_addr_i[1:0] != 2'b00);
    assign granted      = data_req_o & data_gnt_i;

    always_comb begin
        unique case (lmul_q)
            LMUL_1:  beat_max = beat_cnt_t'(1 * `LSU_BEATS_PER_VREG - 1);
            LMUL_2:  beat_max = beat_cnt_t'(2 * `LSU_BEATS_PER_VREG - 1);
            LMUL_4:  beat_max = beat_cnt_t'(4 * `LSU_BEATS_PER_VREG - 1);
            default: beat_max = beat_cnt_t'(8 * `LSU_BEATS_PER_VREG - 1);
        endcase
    end

    assign last_beat = (beat_q == beat_max);
    assign reg_end   = &beat_q[BEAT_LSB-1:0];
    assign cur_vd    = vd_q + reg_idx_t'(beat_q[4:BEAT_LSB]);

    // right after a fetch the register arrives straight from the register file
    assign cur_data  = fresh_q ? vreg_rd_i : shift_q;

    //////////////////////////////
    // byte enables
    // byte b of beat k belongs to element (4k + b) / element bytes
    always_comb begin
        logic [6:0] byte_off;
        logic [6:0] elem_idx;
        be = '0;
        for (int b = 0; b < `LSU_BE_W; b++) begin
            byte_off = {beat_q, 2'(b)};
            unique case (eew_q)
                EEW_8:   elem_idx = byte_off;
                EEW_16:  elem_idx = {1'b0, byte_off[6:1]};
                default: elem_idx = {2'b00, byte_off[6:2]};
            endcase
            be[b] = ({1'b0, elem_idx} < vl_q) & (~masked_q | v0_mask_i[elem_idx]);
        end
    end

    //////////////////////////////
    // control FSM
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= IDLE;
            beat_q  <= '0;
            fresh_q <= 1'b0;
        end else begin
            fresh_q <= 1'b0;
            unique case (state_q)
                IDLE: begin
                    // a misaligned base is answered at acceptance and dropped
                    if (accept && !misaligned_o) begin
                        beat_q  <= '0;
                        state_q <= op_store_i ? FETCH : ISSUE;
                    end
                end
                FETCH: begin
                    state_q <= ISSUE;
                    fresh_q <= 1'b1;
                end
                ISSUE: begin
                    if (granted) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= IDLE;
                        end else if (store_q && reg_end) begin
                            state_q <= FETCH;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            store_q  <= op_store_i;
            masked_q <= op_masked_i;
            eew_q    <= op_eew_i;
            lmul_q   <= op_lmul_i;
            vl_q     <= op_vl_i;
            vd_q     <= op_vd_i;
            addr_q   <= op_addr_i;
        end else if (granted) begin
            addr_q   <= addr_q + addr_t'(`LSU_VMEM_W / 8);
        end
        // store words leave from the low end of the register
        if (state_q == ISSUE && store_q) begin
            shift_q <= granted ? (cur_data >> `LSU_VMEM_W) : cur_data;
        end
    end

    //////////////////////////////
    // outputs
    assign vreg_rd_addr_o = cur_vd;

    // loads wait for a free queue slot before requesting
    assign data_req_o   = (state_q == ISSUE) & (store_q | ~full_i);
    assign data_addr_o  = addr_q;
    assign data_we_o    = store_q;
    assign data_be_o    = be;
    assign data_wdata_o = cur_data[`LSU_VMEM_W-1:0];

    assign push_o     = granted & ~store_q;
    assign push_reg_o = cur_vd;
    assign push_be_o  = be;

endmodule

//--- hdl/lsu_top.sv
/*
 * vector load/store unit
 * moves vector register groups between the register file and a 32-bit memory port
 */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top (
    input  logic                 clk_i,
    input  logic                 async_rst_ni,
    // instruction
    input  logic                 op_valid_i,
    input  logic                 op_store_i,
    input  logic                 op_masked_i,
    input  lsu_pkg::eew_e        op_eew_i,
    input  lsu_pkg::lmul_e       op_lmul_i,
    input  lsu_pkg::vl_t         op_vl_i,
    input  lsu_pkg::addr_t       op_addr_i,
    input  lsu_pkg::reg_idx_t    op_vd_i,
    output logic                 op_ready_o,
    output logic                 misaligned_o,
    // register file
    input  lsu_pkg::elem_mask_t  v0_mask_i,
    output lsu_pkg::reg_idx_t    vreg_rd_addr_o,
    input  lsu_pkg::vreg_t       vreg_rd_i,
    output logic                 vreg_wr_en_o,
    output lsu_pkg::reg_idx_t    vreg_wr_addr_o,
    output lsu_pkg::vreg_t       vreg_wr_data_o,
    output lsu_pkg::vmask_t      vreg_wr_mask_o,
    // memory
    output logic                 data_req_o,
    output lsu_pkg::addr_t       data_addr_o,
    output logic                 data_we_o,
    output lsu_pkg::be_t         data_be_o,
    output lsu_pkg::word_t       data_wdata_o,
    input  logic                 data_gnt_i,
    input  logic                 data_rvalid_i,
    input  lsu_pkg::word_t       data_rdata_i
);
    import lsu_pkg::*;

    logic     push;
    reg_idx_t push_reg;
    be_t      push_be;
    logic     full;
    logic     empty;
    reg_idx_t head_reg;
    be_t      head_be;
    logic     wb_idle;

    lsu_req_gen u_req_gen (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_valid_i     (op_valid_i),
        .op_store_i     (op_store_i),
        .op_masked_i    (op_masked_i),
        .op_eew_i       (op_eew_i),
        .op_lmul_i      (op_lmul_i),
        .op_vl_i        (op_vl_i),
        .op_addr_i      (op_addr_i),
        .op_vd_i        (op_vd_i),
        .v0_mask_i      (v0_mask_i),
        .vreg_rd_i      (vreg_rd_i),
        .data_gnt_i     (data_gnt_i),
        .full_i         (full),
        .empty_i        (empty),
        .wb_idle_i      (wb_idle),
        .op_ready_o     (op_ready_o),
        .misaligned_o   (misaligned_o),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .data_req_o     (data_req_o),
        .data_addr_o    (data_addr_o),
        .data_we_o      (data_we_o),
        .data_be_o      (data_be_o),
        .data_wdata_o   (data_wdata_o),
        .push_o         (push),
        .push_reg_o     (push_reg),
        .push_be_o      (push_be)
    );

    // every read-valid retires the oldest queued load beat
    lsu_load_queue #(
        .DEPTH (`LSU_QUEUE_DEPTH)
    ) u_load_queue (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .push_i       (push),
        .push_reg_i   (push_reg),
        .push_be_i    (push_be),
        .pop_i        (data_rvalid_i),
        .full_o       (full),
        .empty_o      (empty),
        .head_reg_o   (head_reg),
        .head_be_o    (head_be)
    );

    lsu_load_wb u_load_wb (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .rvalid_i       (data_rvalid_i),
        .rdata_i        (data_rdata_i),
        .beat_reg_i     (head_reg),
        .beat_be_i      (head_be),
        .idle_o         (wb_idle),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_data_o (vreg_wr_data_o),
        .vreg_wr_mask_o (vreg_wr_mask_o)
    );

endmodule

//--- tb/lsu_properties.sv
/*
 * vector LSU protocol checks
 * memory request stability, alignment and reset behavior of the top level
 */
`timescale 1ns/1ps

module lsu_properties (
    input logic            clk_i,
    input logic            async_rst_ni,
    input logic            data_req_o,
    input logic            data_gnt_i,
    input lsu_pkg::addr_t  data_addr_o,
    input logic            data_we_o,
    input lsu_pkg::be_t    data_be_o,
    input lsu_pkg::word_t  data_wdata_o,
    input logic            vreg_wr_en_o
);

    // a request waits with all its fields unchanged until granted
    req_stable_until_gnt: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o)
            && $stable(data_we_o) && $stable(data_be_o) && $stable(data_wdata_o)
    ) else $error("memory request changed before it was granted");

    addr_word_aligned: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        data_req_o |-> data_addr_o[1:0] == 2'b00
    ) else $error("memory request address is not word aligned");

    quiet_in_reset: assert property (
        @(posedge clk_i)
        !async_rst_ni |-> !data_req_o && !vreg_wr_en_o
    ) else $error("request or register write active during reset");

endmodule

//--- tb/lsu_tb.sv
/*
 * vector LSU testbench
 * random loads and stores against memory and register-file models with a byte-level reference
 */
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int MEM_BYTES   = 1024;
    localparam int VREG_BYTES  = `LSU_VREG_W / 8;
    localparam int NUM_OPS     = 80;
    localparam int ACCEPT_WAIT = 50;
    localparam int DONE_WAIT   = 2000;

    logic        clk_i;
    logic        async_rst_ni;
    logic        op_valid_i;
    logic        op_store_i;
    logic        op_masked_i;
    eew_e        op_eew_i;
    lmul_e       op_lmul_i;
    vl_t         op_vl_i;
    addr_t       op_addr_i;
    reg_idx_t    op_vd_i;
    logic        op_ready_o;
    logic        misaligned_o;
    elem_mask_t  v0_mask_i;
    reg_idx_t    vreg_rd_addr_o;
    vreg_t       vreg_rd_i;
    logic        vreg_wr_en_o;
    reg_idx_t    vreg_wr_addr_o;
    vreg_t       vreg_wr_data_o;
    vmask_t      vreg_wr_mask_o;
    logic        data_req_o;
    addr_t       data_addr_o;
    logic        data_we_o;
    be_t         data_be_o;
    word_t       data_wdata_o;
    logic        data_gnt_i;
    logic        data_rvalid_i;
    word_t       data_rdata_i;

    // memory and register file, plus their expected contents
    logic [7:0]  mem     [MEM_BYTES];
    logic [7:0]  exp_mem [MEM_BYTES];
    vreg_t       rf      [32];
    vreg_t       exp_rf  [32];
    word_t       rd_data_q [$];
    int          rd_due_q  [$];
    int          seed;
    int          cycle;
    int          req_cnt;
    int          gnt_cnt;
    int          rv_cnt;
    int          wr_cnt;

    lsu_top uut (.*);

    bind lsu_top lsu_properties u_properties (.*);

    always #2 clk_i = ~clk_i;

    //////////////////////////////
    // memory model
    // grants at random and answers loads in order after a random delay
    always @(posedge clk_i) begin
        int    base;
        word_t word;
        cycle++;
        base = int'(data_addr_o[9:0]);
        if (data_req_o) begin
            req_cnt++;
        end
        if (data_rvalid_i) begin
            rv_cnt++;
        end
        if (data_req_o && data_gnt_i) begin
            gnt_cnt++;
            for (int b = 0; b < `LSU_BE_W; b++) begin
                if (data_we_o && data_be_o[b]) begin
                    mem[base + b] = data_wdata_o[8 * b +: 8];
                end
                word[8 * b +: 8] = mem[base + b];
            end
            if (!data_we_o) begin
                rd_data_q.push_back(word);
                rd_due_q.push_back(cycle + ($random(seed) & 7));
            end
        end
        // about three grants in four cycles
        data_gnt_i <= (($random(seed) & 3) != 0);
        if (rd_due_q.size() != 0 && rd_due_q[0] <= cycle) begin
            data_rvalid_i <= 1'b1;
            data_rdata_i  <= rd_data_q.pop_front();
            void'(rd_due_q.pop_front());
        end else begin
            data_rvalid_i <= 1'b0;
        end
    end

    //////////////////////////////
    // register file model
    // read data follows the address by one cycle
    always @(posedge clk_i) begin
        vreg_rd_i <= rf[vreg_rd_addr_o];
        if (vreg_wr_en_o) begin
            wr_cnt++;
            for (int i = 0; i < VREG_BYTES; i++) begin
                if (vreg_wr_mask_o[i]) begin
                    rf[vreg_wr_addr_o][8 * i +: 8] = vreg_wr_data_o[8 * i +: 8];
                end
            end
        end
    end

    task automatic report_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // byte g of the group belongs to element g / element bytes
    task automatic build_expected(input logic store, input logic masked, input int ebytes,
                                  input int nreg, input int vl, input int base,
                                  input int vd, input elem_mask_t v0);
        int elem;
        exp_mem = mem;
        exp_rf  = rf;
        for (int g = 0; g < nreg * VREG_BYTES; g++) begin
            elem = g / ebytes;
            if (elem < vl && (!masked || v0[elem])) begin
                if (store) begin
                    exp_mem[base + g] = rf[vd + g / VREG_BYTES][8 * (g % VREG_BYTES) +: 8];
                end else begin
                    exp_rf[vd + g / VREG_BYTES][8 * (g % VREG_BYTES) +: 8] = mem[base + g];
                end
            end
        end
    endtask

    task automatic compare_state();
        for (int a = 0; a < MEM_BYTES; a++) begin
            assert (mem[a] === exp_mem[a]) else begin
                $display("CHECK FAILED mem[0x%03h] got 0x%02h expected 0x%02h",
                         a, mem[a], exp_mem[a]);
                report_failure();
            end
        end
        for (int r = 0; r < 32; r++) begin
            assert (rf[r] === exp_rf[r]) else begin
                $display("CHECK FAILED vreg[%0d] got 0x%032h expected 0x%032h",
                         r, rf[r], exp_rf[r]);
                report_failure();
            end
        end
    endtask

    task automatic run_instruction(input logic store, input logic masked, input eew_e eew,
                                   input lmul_e lmul, input vl_t vl, input addr_t addr,
                                   input reg_idx_t vd, input elem_mask_t v0);
        int   nreg;
        int   waited;
        int   req_start;
        int   gnt_start;
        int   rv_start;
        int   wr_start;
        logic misal;
        nreg  = 1 << lmul;
        misal = (addr[1:0] != 2'b00);
        build_expected(store, masked, 1 << eew, misal ? 0 : nreg, int'(vl),
                       int'(addr[9:0]), int'(vd), v0);
        @(posedge clk_i);
        op_valid_i  <= 1'b1;
        op_store_i  <= store;
        op_masked_i <= masked;
        op_eew_i    <= eew;
        op_lmul_i   <= lmul;
        op_vl_i     <= vl;
        op_addr_i   <= addr;
        op_vd_i     <= vd;
        v0_mask_i   <= v0;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
        end while (!op_ready_o && waited < ACCEPT_WAIT);
        assert (op_ready_o) else begin
            $display("timeout while waiting for the instruction to be accepted");
            report_failure();
        end
        // acceptance happens at this edge
        op_valid_i <= 1'b0;
        assert (misaligned_o === misal) else begin
            $display("CHECK FAILED misaligned_o got 0x%0h expected 0x%0h", misaligned_o, misal);
            report_failure();
        end
        req_start = req_cnt;
        gnt_start = gnt_cnt;
        rv_start  = rv_cnt;
        wr_start  = wr_cnt;
        if (misal) begin
            repeat (8) @(posedge clk_i);
        end else begin
            waited = 0;
            do begin
                @(posedge clk_i);
                waited++;
            end while (!op_ready_o && waited < DONE_WAIT);
            assert (op_ready_o) else begin
                $display("timeout while waiting for the instruction to finish");
                report_failure();
            end
            // a load may only become ready again with its last register write
            assert (store || (rv_cnt - rv_start == `LSU_BEATS_PER_VREG * nreg
                              && !data_rvalid_i && vreg_wr_en_o)) else begin
                $display("ready for a new instruction before the load was written back");
                report_failure();
            end
            // last register write lands at this edge
            @(posedge clk_i);
        end
        assert (!misal || req_cnt == req_start) else begin
            $display("memory request issued for a misaligned instruction");
            report_failure();
        end
        assert (misal || gnt_cnt - gnt_start == `LSU_BEATS_PER_VREG * nreg) else begin
            $display("CHECK FAILED data_gnt_i beats got 0x%0h expected 0x%0h",
                     gnt_cnt - gnt_start, `LSU_BEATS_PER_VREG * nreg);
            report_failure();
        end
        assert (wr_cnt - wr_start == ((store || misal) ? 0 : nreg)) else begin
            $display("CHECK FAILED vreg_wr_en_o pulses got 0x%0h expected 0x%0h",
                     wr_cnt - wr_start, (store || misal) ? 0 : nreg);
            report_failure();
        end
        compare_state();
    endtask

    initial begin
        logic [31:0] r;
        eew_e        eew;
        lmul_e       lmul;
        int          vlmax;
        vl_t         vl;
        addr_t       addr;
        reg_idx_t    vd;
        seed          = 72;
        clk_i         = 1'b0;
        async_rst_ni  = 1'b1;
        op_valid_i    = 1'b0;
        op_store_i    = 1'b0;
        op_masked_i   = 1'b0;
        op_eew_i      = EEW_8;
        op_lmul_i     = LMUL_1;
        op_vl_i       = '0;
        op_addr_i     = '0;
        op_vd_i       = '0;
        v0_mask_i     = '0;
        vreg_rd_i     = '0;
        data_gnt_i    = 1'b0;
        data_rvalid_i = 1'b0;
        data_rdata_i  = '0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = 8'($random(seed));
        end
        for (int i = 0; i < 32; i++) begin
            rf[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        #1 async_rst_ni = 1'b0;
        repeat (2) @(posedge clk_i);
        async_rst_ni <= 1'b1;
        @(posedge clk_i);
        assert (op_ready_o && !data_req_o && !vreg_wr_en_o && !misaligned_o) else begin
            $display("outputs are not idle after reset");
            report_failure();
        end
        for (int i = 0; i < NUM_OPS; i++) begin
            r     = $random(seed);
            eew   = eew_e'(r[1:0] % 2'd3);
            lmul  = lmul_e'(r[3:2]);
            vlmax = (VREG_BYTES << lmul) >> eew;
            // even steps run at full vl, odd steps with a random one
            vl    = vl_t'((i % 2 == 0) ? vlmax : $unsigned($random(seed)) % (vlmax + 1));
            addr  = addr_t'($random(seed)) & 32'h0000_037c;
            if (i % 7 == 6) begin
                addr[1:0] = 2'd1 + r[5:4] % 2'd3;
            end
            vd    = reg_idx_t'(r[12:8]) & ~reg_idx_t'((1 << lmul) - 1);
            run_instruction(r[6], (i % 4) >= 2, eew, lmul, vl, addr, vd,
                            {$random(seed), $random(seed), $random(seed), $random(seed)});
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
hdl/lsu_pkg.sv
hdl/lsu_load_queue.sv
hdl/lsu_load_wb.sv
hdl/lsu_req_gen.sv
hdl/lsu_top.sv
tb/lsu_properties.sv
tb/lsu_tb.sv

//--- Makefile
SIM      := verilator
TOP      := lsu_tb
FILELIST := src.f
FLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
